//--- src/armDatapath_settings.svh
`ifndef ARM_DATAPATH_SETTINGS_SVH
`define ARM_DATAPATH_SETTINGS_SVH

// register file and ALU width
`define DATA_WIDTH 64
// fetched instruction word
`define INSTR_WIDTH 32

// sixteen architectural registers, 4-bit index
`define REG_ADDR_WIDTH 4
`define NUM_REGS 16

// immediate sits in bits 11..0, sign bit at 11
`define IMM_WIDTH 12

// opcode field, bits 27..20
`define OPC_LSB 20
`define OPC_MSB 27

// low bit of each register field
`define RN_LSB 16
`define RD_LSB 12
`define RM_LSB 0

`endif

//--- src/armDatapathPkg.sv
`default_nettype none

`include "armDatapath_settings.svh"

package armDatapathPkg;

   // opcode field values seen by the control decoder
   // anything outside this list decodes to a no-op
   typedef enum logic [7:0]
   {
      OPC_ADD  = 8'h10,
      OPC_SUB  = 8'h11,
      OPC_AND  = 8'h12,
      OPC_ORR  = 8'h13,
      // immediate forms, second operand from bits 11..0
      OPC_ADDI = 8'h20,
      OPC_SUBI = 8'h21
   } opcodeE;

   // operation carried down the pipe to the ALU
   typedef enum logic [1:0]
   {
      ALU_ADD = 2'd0,
      ALU_SUB = 2'd1,
      ALU_AND = 2'd2,
      ALU_ORR = 2'd3
   } aluOpE;

   // one register or ALU word
   typedef logic [`DATA_WIDTH-1:0] dataT;

   // register file index
   typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

endpackage

`default_nettype wire

//--- src/instrDecoder.sv
`default_nettype none

`include "armDatapath_settings.svh"

module instrDecoder
(
   input  wire logic [`INSTR_WIDTH-1:0] instr_i,

   // decoded control for the ID/EX register
   output      logic                    regWrite_o,
   output      logic                    useImm_o,
   output      armDatapathPkg::aluOpE   aluOp_o,

   // sign extended immediate and destination index
   output      armDatapathPkg::dataT    imm_o,
   output      armDatapathPkg::regAddrT rd_o
);

   // opcode field viewed through the package enum
   armDatapathPkg::opcodeE opcode;

   assign opcode = armDatapathPkg::opcodeE'(instr_i[`OPC_MSB:`OPC_LSB]);

   // main control
   // known opcodes all write a register, only the immediate forms
   // take the second operand from the instruction word
   always_comb
   begin
      regWrite_o = 1'b1;
      useImm_o   = 1'b0;
      aluOp_o    = armDatapathPkg::ALU_ADD;
      case (opcode)
         armDatapathPkg::OPC_ADD:
         begin
            aluOp_o = armDatapathPkg::ALU_ADD;
         end
         armDatapathPkg::OPC_SUB:
         begin
            aluOp_o = armDatapathPkg::ALU_SUB;
         end
         armDatapathPkg::OPC_AND:
         begin
            aluOp_o = armDatapathPkg::ALU_AND;
         end
         armDatapathPkg::OPC_ORR:
         begin
            aluOp_o = armDatapathPkg::ALU_ORR;
         end
         armDatapathPkg::OPC_ADDI:
         begin
            aluOp_o  = armDatapathPkg::ALU_ADD;
            useImm_o = 1'b1;
         end
         armDatapathPkg::OPC_SUBI:
         begin
            aluOp_o  = armDatapathPkg::ALU_SUB;
            useImm_o = 1'b1;
         end
         default:
         begin
            // unknown opcode, travels as a bubble
            regWrite_o = 1'b0;
         end
      endcase
   end

   // replicate bit 11 into the upper bits
   assign imm_o = {{(`DATA_WIDTH-`IMM_WIDTH){instr_i[`IMM_WIDTH-1]}},
                   instr_i[`IMM_WIDTH-1:0]};

   // Rd field, bits 15..12
   assign rd_o = instr_i[`RD_LSB +: `REG_ADDR_WIDTH];

endmodule

`default_nettype wire

//--- src/operandFetch.sv
`default_nettype none

`include "armDatapath_settings.svh"

module operandFetch
(
   input  wire logic                    clock,
   input  wire logic                    rstN_i,

   // incoming instruction, read fields only
   input  wire logic [`INSTR_WIDTH-1:0] instr_i,

   // write-back port from MEM/WB
   input  wire logic                    wbValid_i,
   input  wire armDatapathPkg::regAddrT wbReg_i,
   input  wire armDatapathPkg::dataT    wbData_i,

   // source indices and their values
   output      armDatapathPkg::regAddrT rn_o,
   output      armDatapathPkg::regAddrT rm_o,
   output      armDatapathPkg::dataT    rnData_o,
   output      armDatapathPkg::dataT    rmData_o
);

   // register array
   armDatapathPkg::dataT regFile [`NUM_REGS];

   // per port write-back hit
   logic rnHit;
   logic rmHit;

   // Rn from bits 19..16, Rm from bits 3..0
   assign rn_o = instr_i[`RN_LSB +: `REG_ADDR_WIDTH];
   assign rm_o = instr_i[`RM_LSB +: `REG_ADDR_WIDTH];

   // write port
   // cleared on reset, one write per cycle from write-back
   always_ff @(posedge clock)
   begin
      if (!rstN_i)
      begin
         for (int i = 0; i < `NUM_REGS; i++)
         begin
            regFile[i] <= '0;
         end
      end
      else if (wbValid_i)
      begin
         regFile[wbReg_i] <= wbData_i;
      end
   end

   // write-through bypass
   // a register being written this cycle is returned straight from
   // the write-back port, which covers the distance-3 dependency
   assign rnHit = wbValid_i && (wbReg_i == rn_o);
   assign rmHit = wbValid_i && (wbReg_i == rm_o);

   // read ports, combinational
   assign rnData_o = rnHit ? wbData_i : regFile[rn_o];
   assign rmData_o = rmHit ? wbData_i : regFile[rm_o];

endmodule

`default_nettype wire

//--- src/executeStage.sv
`default_nettype none

`include "armDatapath_settings.svh"

module executeStage
(
   input  wire logic                    clock,
   input  wire logic                    rstN_i,

   // decoded instruction, ID stage
   input  wire logic                    instrValid_i,
   input  wire logic                    regWrite_i,
   input  wire logic                    useImm_i,
   input  wire armDatapathPkg::aluOpE   aluOp_i,
   input  wire armDatapathPkg::dataT    imm_i,
   input  wire armDatapathPkg::regAddrT rd_i,
   input  wire armDatapathPkg::regAddrT rn_i,
   input  wire armDatapathPkg::regAddrT rm_i,
   input  wire armDatapathPkg::dataT    rnData_i,
   input  wire armDatapathPkg::dataT    rmData_i,

   // write-back triple from MEM/WB
   output      logic                    wbValid_o,
   output      armDatapathPkg::regAddrT wbReg_o,
   output      armDatapathPkg::dataT    wbData_o
);

   // ID/EX
   logic                    idExValid;
   logic                    idExUseImm;
   armDatapathPkg::aluOpE   idExAluOp;
   armDatapathPkg::dataT    idExImm;
   armDatapathPkg::regAddrT idExRd;
   armDatapathPkg::regAddrT idExRn;
   armDatapathPkg::regAddrT idExRm;
   armDatapathPkg::dataT    idExRnData;
   armDatapathPkg::dataT    idExRmData;

   // EX/MEM
   logic                    exMemValid;
   armDatapathPkg::regAddrT exMemRd;
   armDatapathPkg::dataT    exMemData;

   // ALU inputs after forwarding, and result
   armDatapathPkg::dataT    fwdA;
   armDatapathPkg::dataT    fwdB;
   armDatapathPkg::dataT    aluB;
   armDatapathPkg::dataT    aluResult;

   // ID/EX register
   // write valid only for a strobed instruction with a known opcode
   always_ff @(posedge clock)
   begin
      if (!rstN_i)
      begin
         idExValid  <= 1'b0;
         idExUseImm <= 1'b0;
         idExAluOp  <= armDatapathPkg::ALU_ADD;
         idExImm    <= '0;
         idExRd     <= '0;
         idExRn     <= '0;
         idExRm     <= '0;
         idExRnData <= '0;
         idExRmData <= '0;
      end
      else
      begin
         idExValid  <= instrValid_i && regWrite_i;
         idExUseImm <= useImm_i;
         idExAluOp  <= aluOp_i;
         idExImm    <= imm_i;
         idExRd     <= rd_i;
         idExRn     <= rn_i;
         idExRm     <= rm_i;
         idExRnData <= rnData_i;
         idExRmData <= rmData_i;
      end
   end

   // forwarding unit
   // EX/MEM is the younger result, so it is checked first
   always_comb
   begin
      if (exMemValid && (exMemRd == idExRn))
         fwdA = exMemData;
      else if (wbValid_o && (wbReg_o == idExRn))
         fwdA = wbData_o;
      else
         fwdA = idExRnData;

      if (exMemValid && (exMemRd == idExRm))
         fwdB = exMemData;
      else if (wbValid_o && (wbReg_o == idExRm))
         fwdB = wbData_o;
      else
         fwdB = idExRmData;
   end

   // immediate forms ignore Rm
   assign aluB = idExUseImm ? idExImm : fwdB;

   // ALU
   always_comb
   begin
      case (idExAluOp)
         armDatapathPkg::ALU_ADD: aluResult = fwdA + aluB;
         armDatapathPkg::ALU_SUB: aluResult = fwdA - aluB;
         armDatapathPkg::ALU_AND: aluResult = fwdA & aluB;
         default:                 aluResult = fwdA | aluB;
      endcase
   end

   // EX/MEM and MEM/WB
   // no memory stage work, the result just moves on
   always_ff @(posedge clock)
   begin
      if (!rstN_i)
      begin
         exMemValid <= 1'b0;
         exMemRd    <= '0;
         exMemData  <= '0;
         wbValid_o  <= 1'b0;
         wbReg_o    <= '0;
         wbData_o   <= '0;
      end
      else
      begin
         exMemValid <= idExValid;
         exMemRd    <= idExRd;
         exMemData  <= aluResult;
         wbValid_o  <= exMemValid;
         wbReg_o    <= exMemRd;
         wbData_o   <= exMemData;
      end
   end

endmodule

`default_nettype wire

//--- src/armDatapath.sv
`default_nettype none

`include "armDatapath_settings.svh"

module armDatapath
(
   input  wire logic                    clock,
   input  wire logic                    rstN_i,

   // instruction strobe, no back-pressure
   input  wire logic                    instrValid_i,
   input  wire logic [`INSTR_WIDTH-1:0] instr_i,

   // register writes as MEM/WB commits them
   output      logic                    wbValid_o,
   output      armDatapathPkg::regAddrT wbReg_o,
   output      armDatapathPkg::dataT    wbData_o
);

   // decoder to execute
   logic                    regWrite;
   logic                    useImm;
   armDatapathPkg::aluOpE   aluOp;
   armDatapathPkg::dataT    imm;
   armDatapathPkg::regAddrT rd;

   // operand fetch to execute
   armDatapathPkg::regAddrT rn;
   armDatapathPkg::regAddrT rm;
   armDatapathPkg::dataT    rnData;
   armDatapathPkg::dataT    rmData;

   // control decode, same cycle as the register read
   instrDecoder instrDecoder_inst
   (
      .instr_i    (instr_i),
      .regWrite_o (regWrite),
      .useImm_o   (useImm),
      .aluOp_o    (aluOp),
      .imm_o      (imm),
      .rd_o       (rd)
   );

   // register file, written back from the end of the pipe
   operandFetch operandFetch_inst
   (
      .clock      (clock),
      .rstN_i     (rstN_i),
      .instr_i    (instr_i),
      .wbValid_i  (wbValid_o),
      .wbReg_i    (wbReg_o),
      .wbData_i   (wbData_o),
      .rn_o       (rn),
      .rm_o       (rm),
      .rnData_o   (rnData),
      .rmData_o   (rmData)
   );

   // ID/EX through MEM/WB
   executeStage executeStage_inst
   (
      .clock        (clock),
      .rstN_i       (rstN_i),
      .instrValid_i (instrValid_i),
      .regWrite_i   (regWrite),
      .useImm_i     (useImm),
      .aluOp_i      (aluOp),
      .imm_i        (imm),
      .rd_i         (rd),
      .rn_i         (rn),
      .rm_i         (rm),
      .rnData_i     (rnData),
      .rmData_i     (rmData),
      .wbValid_o    (wbValid_o),
      .wbReg_o      (wbReg_o),
      .wbData_o     (wbData_o)
   );

endmodule

`default_nettype wire

//--- bench/armDatapathTb.sv
`default_nettype none

`include "armDatapath_settings.svh"

module armDatapathTb;

   // run length for the cycle limit
   localparam int RESET_CYCLES    = 3;
   localparam int DIRECTED_CYCLES = 40;
   localparam int RANDOM_COUNT    = 300;
   localparam int MAX_GAP         = 2;
   localparam int DRAIN_CYCLES    = 6;
   localparam int STIM_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES
                                    + RANDOM_COUNT * (MAX_GAP + 1) + DRAIN_CYCLES;
   localparam int CYCLE_LIMIT     = 2 * STIM_CYCLES + 20;

   // accepting edge to the edge that samples MEM/WB
   localparam int PIPE_DEPTH  = 3;
   localparam int DRIVE_DELAY = 10;

   // expected write-back where wr low marks a bubble
   typedef struct packed
   {
      int                      tag;
      logic                    wr;
      armDatapathPkg::regAddrT rd;
      armDatapathPkg::dataT    data;
   } expT;

   logic                    clock;
   logic                    rstN;
   logic                    instrValid;
   logic [`INSTR_WIDTH-1:0] instr;
   logic                    wbValid;
   armDatapathPkg::regAddrT wbReg;
   armDatapathPkg::dataT    wbData;

   // reference state
   armDatapathPkg::dataT    modelRegs [`NUM_REGS];
   expT                     expQ [$];
   expT                     head;
   int                      cycleCount = 0;

   // random stream scratch
   int                      gap;
   int                      sel;
   logic [7:0]              opc;
   armDatapathPkg::regAddrT rd;
   armDatapathPkg::regAddrT rn;
   armDatapathPkg::regAddrT rm;
   armDatapathPkg::regAddrT lastRd;

   armDatapath armDatapath_inst
   (
      .clock        (clock),
      .rstN_i       (rstN),
      .instrValid_i (instrValid),
      .instr_i      (instr),
      .wbValid_o    (wbValid),
      .wbReg_o      (wbReg),
      .wbData_o     (wbData)
   );

   initial
   begin
      clock = 1'b0;
      forever #50 clock = ~clock;
   end

   task automatic abortRun();
      $display("test failed");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic valueError(input string msg);
      $display("ERR %0t %s", $time, msg);
      abortRun();
   endtask

   // packs opcode 27..20, Rn 19..16, Rd 15..12 and low 11..0
   function automatic logic [`INSTR_WIDTH-1:0] buildInstr(input logic [7:0] op,
      input armDatapathPkg::regAddrT dst, input armDatapathPkg::regAddrT src,
      input logic [11:0] low);
      logic [`INSTR_WIDTH-1:0] word;
      word = '0;
      word[`OPC_MSB:`OPC_LSB] = op;
      word[`RN_LSB +: `REG_ADDR_WIDTH] = src;
      word[`RD_LSB +: `REG_ADDR_WIDTH] = dst;
      word[11:0] = low;
      return word;
   endfunction

   // six known opcodes and a range of unknown ones
   function automatic logic [7:0] pickOpcode(input int s);
      case (s)
         0: return armDatapathPkg::OPC_ADD;
         1: return armDatapathPkg::OPC_SUB;
         2: return armDatapathPkg::OPC_AND;
         3: return armDatapathPkg::OPC_ORR;
         4: return armDatapathPkg::OPC_ADDI;
         5: return armDatapathPkg::OPC_SUBI;
         default: return 8'h80 | 8'($urandom % 128);
      endcase
   endfunction

   // reference model step for one accepted instruction in program order
   task automatic modelInstr(input logic [`INSTR_WIDTH-1:0] word, input int tag);
      logic [7:0]              op;
      armDatapathPkg::regAddrT dst;
      armDatapathPkg::dataT    a;
      armDatapathPkg::dataT    b;
      armDatapathPkg::dataT    imm;
      armDatapathPkg::dataT    res;
      logic                    known;
      expT                     e;
      op    = word[`OPC_MSB:`OPC_LSB];
      dst   = word[`RD_LSB +: `REG_ADDR_WIDTH];
      a     = modelRegs[word[`RN_LSB +: `REG_ADDR_WIDTH]];
      b     = modelRegs[word[`RM_LSB +: `REG_ADDR_WIDTH]];
      // signed 12-bit field widens with its sign
      imm   = $signed(word[`IMM_WIDTH-1:0]);
      known = 1'b1;
      res   = '0;
      case (op)
         armDatapathPkg::OPC_ADD:  res = a + b;
         armDatapathPkg::OPC_SUB:  res = a - b;
         armDatapathPkg::OPC_AND:  res = a & b;
         armDatapathPkg::OPC_ORR:  res = a | b;
         armDatapathPkg::OPC_ADDI: res = a + imm;
         armDatapathPkg::OPC_SUBI: res = a - imm;
         default:                  known = 1'b0;
      endcase
      if (known)
         modelRegs[dst] = res;
      e.tag  = tag;
      e.wr   = known;
      e.rd   = known ? dst : '0;
      e.data = res;
      expQ.push_back(e);
   endtask

   // accepted at the next edge whose number is the current count
   task automatic issueInstr(input logic [`INSTR_WIDTH-1:0] word);
      @(posedge clock);
      #DRIVE_DELAY;
      instrValid = 1'b1;
      instr      = word;
      modelInstr(word, cycleCount);
   endtask

   // strobe low with a garbage word that must be ignored
   task automatic idleCycle();
      @(posedge clock);
      #DRIVE_DELAY;
      instrValid = 1'b0;
      instr      = $urandom;
   endtask

   // write-back monitor and cycle limit
   always @(posedge clock)
   begin
      if (cycleCount >= CYCLE_LIMIT)
      begin
         $display("timeout: run did not end within %0d cycles", CYCLE_LIMIT);
         abortRun();
      end
      if (rstN)
      begin
         if (expQ.size() != 0 && expQ[0].tag + PIPE_DEPTH == cycleCount)
         begin
            head = expQ.pop_front();
            if (head.wr)
            begin
               assert (wbValid === 1'b1)
               else valueError($sformatf("missing write-back to r%0d", head.rd));
               assert (wbReg === head.rd)
               else valueError($sformatf("wbReg %0d, expected %0d", wbReg, head.rd));
               assert (wbData === head.data)
               else valueError($sformatf("r%0d data %h, expected %h",
                                         head.rd, wbData, head.data));
            end
            else
            begin
               // unknown opcode slot
               assert (wbValid === 1'b0)
               else valueError("write-back from a no-op instruction");
            end
         end
         else
         begin
            // idle slot or nothing in flight
            assert (wbValid === 1'b0)
            else valueError("write-back with no instruction accepted");
         end
      end
      cycleCount <= cycleCount + 1;
   end

   initial
   begin
      void'($urandom(65));
      rstN       = 1'b0;
      instrValid = 1'b0;
      instr      = '0;
      lastRd     = '0;
      for (int i = 0; i < `NUM_REGS; i++)
         modelRegs[i] = '0;

      repeat (RESET_CYCLES) @(posedge clock);
      #DRIVE_DELAY;
      rstN = 1'b1;

      // quiet pipe after reset
      repeat (4) idleCycle();

      // basic ops with dependencies at distance 1 and 2
      issueInstr(buildInstr(armDatapathPkg::OPC_ADDI, 4'd1, 4'd0, 12'h005));
      issueInstr(buildInstr(armDatapathPkg::OPC_ADDI, 4'd2, 4'd0, 12'hffd));
      issueInstr(buildInstr(armDatapathPkg::OPC_ADD, 4'd3, 4'd1, 12'h002));
      issueInstr(buildInstr(armDatapathPkg::OPC_SUB, 4'd4, 4'd3, 12'h001));
      issueInstr(buildInstr(armDatapathPkg::OPC_AND, 4'd5, 4'd4, 12'h002));
      issueInstr(buildInstr(armDatapathPkg::OPC_ORR, 4'd6, 4'd5, 12'h001));
      // negative immediate of -100
      issueInstr(buildInstr(armDatapathPkg::OPC_SUBI, 4'd7, 4'd6, 12'hf9c));
      idleCycle();
      issueInstr(buildInstr(armDatapathPkg::OPC_ADD, 4'd8, 4'd7, 12'h006));

      // unknown opcode must leave r1 alone
      issueInstr(buildInstr(8'hff, 4'd1, 4'd8, 12'h008));
      issueInstr(buildInstr(armDatapathPkg::OPC_ADD, 4'd9, 4'd1, 12'h001));

      // immediate extremes then distance 3 through the register file bypass
      issueInstr(buildInstr(armDatapathPkg::OPC_ADDI, 4'd10, 4'd0, 12'h7ff));
      issueInstr(buildInstr(armDatapathPkg::OPC_ADDI, 4'd11, 4'd0, 12'h800));
      issueInstr(buildInstr(armDatapathPkg::OPC_ADDI, 4'd12, 4'd0, 12'h001));
      issueInstr(buildInstr(armDatapathPkg::OPC_ADD, 4'd13, 4'd10, 12'h00a));
      issueInstr(buildInstr(armDatapathPkg::OPC_SUB, 4'd14, 4'd11, 12'h00a));

      // well separated plain register read
      repeat (3) idleCycle();
      issueInstr(buildInstr(armDatapathPkg::OPC_ORR, 4'd15, 4'd13, 12'h00e));

      // back to back chain on r1
      repeat (4) issueInstr(buildInstr(armDatapathPkg::OPC_ADDI, 4'd1, 4'd1, 12'h001));
      issueInstr(buildInstr(armDatapathPkg::OPC_AND, 4'd0, 4'd15, 12'h00f));

      // random stream with gaps, unknown opcodes and chains
      for (int n = 0; n < RANDOM_COUNT; n++)
      begin
         gap = $urandom % (MAX_GAP + 1);
         repeat (gap) idleCycle();
         sel = $urandom % 8;
         opc = pickOpcode(sel);
         rd  = 4'($urandom % `NUM_REGS);
         rn  = 4'($urandom % `NUM_REGS);
         rm  = 4'($urandom % `NUM_REGS);
         // reuse the previous destination now and then
         if ($urandom % 3 == 0)
            rn = lastRd;
         if ($urandom % 3 == 0)
            rm = lastRd;
         issueInstr(buildInstr(opc, rd, rn, {8'($urandom), rm}));
         lastRd = rd;
      end

      // let the last results leave MEM/WB
      repeat (DRAIN_CYCLES) idleCycle();

      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- armDatapath.f
+incdir+src
src/armDatapathPkg.sv
src/instrDecoder.sv
src/operandFetch.sv
src/executeStage.sv
src/armDatapath.sv
bench/armDatapathTb.sv

//--- Bender.yml
package:
  name: armDatapath

sources:
  - include_dirs:
      - src
    files:
      - src/armDatapathPkg.sv
      - src/instrDecoder.sv
      - src/operandFetch.sv
      - src/executeStage.sv
      - src/armDatapath.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/armDatapathTb.sv
